// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= busMasterTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+source
source/busMasterPkg.sv
source/commandDecode.sv
source/arbiterHandshake.sv
source/controlFrameSender.sv
source/readDeserializer.sv
source/busMaster.sv
sim/busMaster_chk.sv
sim/busMasterTb.sv

// ==== sim/busMasterTb.sv ====
`timescale 1ns/1ps

`include "busMaster_defs.svh"

module busMasterTb import busMasterPkg::*; ();

    localparam int unsigned CYCLE_LIMIT = 2000;   // ~2x of 20 worst-case transactions
    localparam int unsigned NUM_MAIN    = 18;     // plus two served from pending
    localparam int unsigned NUM_TOTAL   = 20;

    logic     clk;
    logic     rstN;
    logic     start;
    logic     arbCont;
    logic     rD;
    logic     ready;
    logic     arbSend;
    logic     control;
    logic     doneCom;
    dataWordT dataOut;

    int unsigned cycles;
    int unsigned reqSeen;     // request sequences seen by the arbiter model
    int unsigned doneCount;
    dataWordT    expWords[$]; // words sent by the slave model, in order
    dataWordT    expWord;

    busMaster dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .arbCont (arbCont),
        .arbSend (arbSend),
        .rD      (rD),
        .ready   (ready),
        .control (control),
        .doneCom (doneCom),
        .dataOut (dataOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // one-cycle start, called right after a rising edge
    task automatic pulseStart();
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
    endtask

    task automatic waitDone();
        do @(posedge clk); while (!doneCom);
    endtask

    //////////////////////////////
    // timeout and bound checks
    //////////////////////////////
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            stopOnError("timeout, the transactions did not finish in time");
        end else if (dut0.chk0.anyFail) begin
            stopOnError("a bound assertion on the bus master failed");
        end
    end

    // result word against what the slave model sent
    always @(posedge clk) begin
        if (rstN && doneCom) begin
            if (expWords.size() == 0) begin
                stopOnError("doneCom came without a read from the slave");
            end else begin
                expWord = expWords.pop_front();
                doneCount++;
                assert (dataOut == expWord) else stopOnError($sformatf(
                    "Fail: time %0t, dataOut, expected %h, actual %h",
                    $time, expWord, dataOut));
            end
        end
    end

    //////////////////////////////
    // arbiter model
    //////////////////////////////
    initial begin : arbiterModel
        logic [`BM_REQ_LEN-1:0] hist;
        int unsigned            delay;
        hist = '0;
        forever begin
            @(posedge clk);
            hist = {hist[`BM_REQ_LEN-2:0], arbSend};
            if (hist == 5'b11100) begin   // full request seen
                reqSeen++;
                delay = $urandom_range(10, 0);
                repeat (delay) @(posedge clk);
                #2 arbCont = 1'b1;
                do @(posedge clk); while (!doneCom);
                #2 arbCont = 1'b0;
                hist = '0;
            end
        end
    end

    //////////////////////////////
    // slave model
    //////////////////////////////
    initial begin : slaveModel
        logic [`BM_FRAME_LEN-1:0] hist;
        dataWordT                 word;
        int unsigned              gap;
        int                       b;
        hist = '0;
        forever begin
            @(posedge clk);
            hist = {hist[`BM_FRAME_LEN-2:0], control};
            if (hist == 7'b1111001) begin   // last frame bit just sampled
                word = dataWordT'($urandom);
                expWords.push_back(word);
                for (b = `BM_DATA_WIDTH - 1; b >= 0; b--) begin
                    gap = $urandom_range(3, 0);
                    repeat (gap) begin
                        #2 ready = 1'b0;
                        rD = 1'($urandom);   // noise, must be ignored
                        @(posedge clk);
                    end
                    #2 ready = 1'b1;
                    rD = word[b];
                    @(posedge clk);
                end
                #2 ready = 1'b0;
                rD = 1'b0;
                hist = '0;
            end
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int unsigned t;
        void'($urandom(91051));
        rstN      = 1'b0;
        start     = 1'b0;
        arbCont   = 1'b0;
        rD        = 1'b0;
        ready     = 1'b0;
        cycles    = 0;
        reqSeen   = 0;
        doneCount = 0;
        repeat (16) @(posedge clk);
        #2 rstN = 1'b1;
        repeat (10) @(posedge clk);   // idle outputs before the first start

        for (t = 0; t < NUM_MAIN; t++) begin
            pulseStart();
            if (t == 5 || t == 12) begin
                do @(posedge clk); while (!control);   // frame phase, master busy
                pulseStart();                          // becomes pending
                @(posedge clk);
                pulseStart();                          // dropped
                waitDone();
            end
            waitDone();
        end
        repeat (40) @(posedge clk);   // no stray request afterwards

        if (reqSeen == NUM_TOTAL && doneCount == NUM_TOTAL) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stopOnError($sformatf("wrong number of transactions, %0d requests, %0d done",
                reqSeen, doneCount));
        end
    end

endmodule

// ==== sim/busMaster_chk.sv ====
`timescale 1ns/1ps

module busMasterChk import busMasterPkg::*; (
    input logic     clk,
    input logic     rstN,
    input logic     start,
    input logic     cmdStrobe,
    input logic     busy,
    input logic     arbSend,
    input logic     arbCont,
    input logic     frameGo,
    input logic     control,
    input logic     doneCom,
    input dataWordT dataOut
);

    logic seenStart;
    logic quietErr  = 1'b0;
    logic issueErr  = 1'b0;
    logic reqErr    = 1'b0;
    logic ackErr    = 1'b0;
    logic frameErr  = 1'b0;
    logic pulseErr  = 1'b0;
    logic anyFail;

    assign anyFail = quietErr | issueErr | reqErr | ackErr | frameErr | pulseErr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            seenStart <= 1'b0;
        end else if (start) begin
            seenStart <= 1'b1;
        end
    end

    //////////////////////////////
    // line protocol
    //////////////////////////////
    quietAfterReset: assert property (@(posedge clk) disable iff (!rstN)
        !seenStart |-> (!arbSend && !control && !doneCom && dataOut == '0))
        else begin
            quietErr = 1'b1;
            $error("outputs active before first start");
        end

    // idle start puts the first request bit out two cycles later
    startToRequest: assert property (@(posedge clk) disable iff (!rstN)
        $past(start && !busy && !cmdStrobe, 2) |-> (arbSend && !$past(arbSend)))
        else begin
            issueErr = 1'b1;
            $error("request did not begin two cycles after an idle start");
        end

    requestBits: assert property (@(posedge clk) disable iff (!rstN)
        $past(cmdStrobe, 5) |-> {$past(arbSend, 4), $past(arbSend, 3), $past(arbSend, 2),
                                 $past(arbSend, 1), arbSend} == 5'b11100)
        else begin
            reqErr = 1'b1;
            $error("request sequence wrong");
        end

    // ack only after two high grant samples
    ackBits: assert property (@(posedge clk) disable iff (!rstN)
        frameGo |-> ({$past(arbSend, 3), $past(arbSend, 2), $past(arbSend, 1)} == 3'b101
                     && $past(arbCont, 5) && $past(arbCont, 6)))
        else begin
            ackErr = 1'b1;
            $error("acknowledge wrong or before grant");
        end

    frameBits: assert property (@(posedge clk) disable iff (!rstN)
        $past(frameGo, 8) |-> ({$past(control, 7), $past(control, 6), $past(control, 5),
                                $past(control, 4), $past(control, 3), $past(control, 2),
                                $past(control, 1)} == 7'b1111001 && !control))
        else begin
            frameErr = 1'b1;
            $error("control frame wrong");
        end

    donePulse: assert property (@(posedge clk) disable iff (!rstN)
        $past(doneCom) |-> !doneCom)
        else begin
            pulseErr = 1'b1;
            $error("doneCom longer than one cycle");
        end

endmodule

bind busMaster busMasterChk chk0 (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .cmdStrobe (cmdStrobe),
    .busy      (busy),
    .arbSend   (arbSend),
    .arbCont   (arbCont),
    .frameGo   (frameGo),
    .control   (control),
    .doneCom   (doneCom),
    .dataOut   (dataOut)
);

// ==== source/arbiterHandshake.sv ====
`timescale 1ns/1ps

`include "busMaster_defs.svh"

module arbiterHandshake import busMasterPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      cmdStrobe,
    input  reqWordT   reqWord,
    input  frameWordT frameWord,
    input  logic      arbCont,
    input  logic      doneCom,
    output logic      arbSend,
    output logic      busy,
    output logic      frameGo,
    output frameWordT frameOut
);

    localparam logic [`BM_ACK_LEN-1:0] ackPattern = `BM_ACK_PATTERN;

    handshakeStateT          state;
    reqWordT                 reqShift;     // remaining request bits
    logic [`BM_ACK_LEN-1:0]  ackShift;     // remaining ack bits
    bitCountT                bitCnt;
    logic [1:0]              arbHist;      // last two arbCont samples
    logic                    granted;

    assign busy    = (state != idle);
    assign granted = (arbHist == 2'b11);

    // grant line history
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            arbHist <= 2'b00;
        end else begin
            arbHist <= {arbHist[0], arbCont};
        end
    end

    //////////////////////////////
    // handshake FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= idle;
            bitCnt  <= '0;
            arbSend <= 1'b0;
            frameGo <= 1'b0;
        end else begin
            frameGo <= 1'b0;
            case (state)
                idle: begin
                    arbSend <= 1'b0;
                    if (cmdStrobe) begin
                        // first request bit goes out right away
                        arbSend <= reqWord[`BM_REQ_LEN-1];
                        bitCnt  <= bitCountT'(1);
                        state   <= request;
                    end
                end

                request: begin
                    if (bitCnt < bitCountT'(`BM_REQ_LEN)) begin
                        arbSend <= reqShift[`BM_REQ_LEN-1];
                        bitCnt  <= bitCnt + 1'b1;
                    end else begin
                        arbSend <= 1'b0;
                        bitCnt  <= '0;
                        state   <= waitGrant;
                    end
                end

                waitGrant: begin
                    arbSend <= 1'b0;
                    if (granted) begin            // arbiter held the line two samples
                        arbSend <= ackPattern[`BM_ACK_LEN-1];
                        bitCnt  <= bitCountT'(1);
                        state   <= acknowledge;
                    end
                end

                acknowledge: begin
                    if (bitCnt < bitCountT'(`BM_ACK_LEN)) begin
                        arbSend <= ackShift[`BM_ACK_LEN-1];
                        bitCnt  <= bitCnt + 1'b1;
                    end else begin
                        arbSend <= 1'b0;
                        bitCnt  <= '0;
                        frameGo <= 1'b1;          // hand over to the frame sender
                        state   <= transfer;
                    end
                end

                transfer: begin
                    arbSend <= 1'b0;
                    if (doneCom) begin
                        state <= idle;
                    end
                end

                default: begin
                    arbSend <= 1'b0;
                    state   <= idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // shift registers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (state == idle && cmdStrobe) begin
            reqShift <= reqWord << 1;
            frameOut <= frameWord;
        end else if (state == request) begin
            reqShift <= reqShift << 1;
        end

        if (state == waitGrant && granted) begin
            ackShift <= ackPattern << 1;   // MSB already on the line
        end else if (state == acknowledge) begin
            ackShift <= ackShift << 1;
        end
    end

endmodule

// ==== source/busMaster.sv ====
`timescale 1ns/1ps

module busMaster import busMasterPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     start,

    // arbiter
    input  logic     arbCont,
    output logic     arbSend,

    // slave
    input  logic     rD,
    input  logic     ready,
    output logic     control,

    // result
    output logic     doneCom,
    output dataWordT dataOut
);

    //////////////////////////////
    // internal wires
    //////////////////////////////
    logic      cmdStrobe;
    logic      busy;
    reqWordT   reqWord;
    frameWordT frameWord;
    logic      frameGo;
    frameWordT frameOut;
    logic      readGo;

    // decode, holds one pending start
    commandDecode decode0 (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .busy      (busy),
        .cmdStrobe (cmdStrobe),
        .reqWord   (reqWord),
        .frameWord (frameWord)
    );

    // execute, arbiter side
    arbiterHandshake handshake0 (
        .clk       (clk),
        .rstN      (rstN),
        .cmdStrobe (cmdStrobe),
        .reqWord   (reqWord),
        .frameWord (frameWord),
        .arbCont   (arbCont),
        .doneCom   (doneCom),     // ends the transaction
        .arbSend   (arbSend),
        .busy      (busy),
        .frameGo   (frameGo),
        .frameOut  (frameOut)
    );

    // execute, slave control line
    controlFrameSender frameSender0 (
        .clk      (clk),
        .rstN     (rstN),
        .frameGo  (frameGo),
        .frameOut (frameOut),
        .control  (control),
        .readGo   (readGo)
    );

    // result
    readDeserializer reader0 (
        .clk     (clk),
        .rstN    (rstN),
        .readGo  (readGo),
        .rD      (rD),
        .ready   (ready),
        .dataOut (dataOut),
        .doneCom (doneCom)
    );

endmodule

// ==== source/busMasterPkg.sv ====
package busMasterPkg;

`include "busMaster_defs.svh"

    //////////////////////////////
    // data carried on the lines
    //////////////////////////////

    // one word read from the slave
    typedef logic [`BM_DATA_WIDTH-1:0] dataWordT;

    // sync ones then slave id
    typedef logic [`BM_REQ_LEN-1:0] reqWordT;

    // sync ones, slave id, r/w bit
    typedef logic [`BM_FRAME_LEN-1:0] frameWordT;

    typedef logic [`BM_COUNT_WIDTH-1:0] bitCountT;

    //////////////////////////////
    // arbiter handshake FSM
    //////////////////////////////
    typedef enum logic [2:0] {
        idle        = 3'd0,
        request     = 3'd1,   // request bits on arbSend
        waitGrant   = 3'd2,
        acknowledge = 3'd3,   // 1,0,1 on arbSend
        transfer    = 3'd4    // frame and read in progress
    } handshakeStateT;

endpackage

// ==== source/busMaster_defs.svh ====
`ifndef BUS_MASTER_DEFS_SVH
`define BUS_MASTER_DEFS_SVH

//////////////////////////////
// read side
//////////////////////////////
`define BM_DATA_WIDTH      8
`define BM_COUNT_WIDTH     4     // holds BM_DATA_WIDTH

//////////////////////////////
// arbiter side
//////////////////////////////
`define BM_REQ_LEN         5
`define BM_SYNC_ONES_REQ   2     // leading ones of the request
`define BM_ACK_LEN         3
`define BM_ACK_PATTERN     3'b101

//////////////////////////////
// slave side
//////////////////////////////
`define BM_FRAME_LEN       7
`define BM_SYNC_ONES_FRAME 3     // leading ones of the frame
`define BM_SLAVE_ID        3'b100
`define BM_READ_BIT        1'b1  // r/w bit of the frame, read only

`endif

// ==== source/commandDecode.sv ====
`timescale 1ns/1ps

`include "busMaster_defs.svh"

module commandDecode import busMasterPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      start,
    input  logic      busy,
    output logic      cmdStrobe,
    output reqWordT   reqWord,
    output frameWordT frameWord
);

    logic pending;   // one start waiting for the bus
    logic issue;

    // busy lags cmdStrobe by a cycle, so a strobe in flight blocks a second one
    assign issue = (start | pending) & ~busy & ~cmdStrobe;

    //////////////////////////////
    // command control
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending   <= 1'b0;
            cmdStrobe <= 1'b0;
        end else begin
            cmdStrobe <= issue;
            if (issue) begin
                // a start in the same cycle as a pending issue stays queued
                pending <= pending & start;
            end else if (start) begin
                pending <= 1'b1;   // extra starts while pending are dropped
            end
        end
    end

    //////////////////////////////
    // request and frame words
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (issue) begin
            reqWord   <= {{`BM_SYNC_ONES_REQ{1'b1}}, `BM_SLAVE_ID};
            frameWord <= {{`BM_SYNC_ONES_FRAME{1'b1}}, `BM_SLAVE_ID, `BM_READ_BIT};
        end
    end

endmodule

// ==== source/controlFrameSender.sv ====
`timescale 1ns/1ps

`include "busMaster_defs.svh"

module controlFrameSender import busMasterPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      frameGo,
    input  frameWordT frameOut,
    output logic      control,
    output logic      readGo
);

    logic      sending;
    frameWordT frameShift;
    bitCountT  bitCnt;   // frame bits already driven

    //////////////////////////////
    // serializer control
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sending <= 1'b0;
            bitCnt  <= '0;
            control <= 1'b0;
            readGo  <= 1'b0;
        end else begin
            readGo <= 1'b0;
            if (!sending) begin
                control <= 1'b0;
                if (frameGo) begin
                    control <= frameOut[`BM_FRAME_LEN-1];   // MSB first
                    bitCnt  <= bitCountT'(1);
                    sending <= 1'b1;
                end
            end else if (bitCnt < bitCountT'(`BM_FRAME_LEN)) begin
                control <= frameShift[`BM_FRAME_LEN-1];
                bitCnt  <= bitCnt + 1'b1;
            end else begin
                // frame done, line back low
                control <= 1'b0;
                bitCnt  <= '0;
                sending <= 1'b0;
                readGo  <= 1'b1;
            end
        end
    end

    // frame payload
    always_ff @(posedge clk) begin
        if (!sending && frameGo) begin
            frameShift <= frameOut << 1;
        end else if (sending) begin
            frameShift <= frameShift << 1;
        end
    end

endmodule

// ==== source/readDeserializer.sv ====
`timescale 1ns/1ps

`include "busMaster_defs.svh"

module readDeserializer import busMasterPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     readGo,
    input  logic     rD,
    input  logic     ready,
    output dataWordT dataOut,
    output logic     doneCom
);

    logic     armed;
    dataWordT shiftIn;   // bits collected so far
    bitCountT bitCnt;
    logic     takeBit;
    logic     lastBit;

    // read window opens with readGo, ready outside it is ignored
    assign takeBit = (readGo | armed) & ready;
    assign lastBit = takeBit & (bitCnt == bitCountT'(`BM_DATA_WIDTH - 1));

    //////////////////////////////
    // read control
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            armed   <= 1'b0;
            bitCnt  <= '0;
            doneCom <= 1'b0;
            dataOut <= '0;
        end else begin
            doneCom <= lastBit;   // one cycle after the last bit
            if (lastBit) begin
                armed   <= 1'b0;
                bitCnt  <= '0;
                dataOut <= {shiftIn[`BM_DATA_WIDTH-2:0], rD};
            end else begin
                if (readGo) begin
                    armed <= 1'b1;
                end
                if (takeBit) begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // data path
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (takeBit) begin
            shiftIn <= {shiftIn[`BM_DATA_WIDTH-2:0], rD};   // MSB arrives first
        end
    end

endmodule
